/* sim.f */
+incdir+src
src/mips_pkg.sv
src/bus_arbiter.sv
src/fetch_unit.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/load_store_unit.sv
src/mips_cpu_bus.sv
tests/mips_cpu_properties.sv
tests/mips_cpu_tb.sv

/* tests/mips_vectors.txt */
# T name stall_pct | M addr nwords word... | V v0 | D addr word | E ends a test
# R name stall_pct reruns the last test; all values hex except stall_pct and nwords
T alu_ops 0
M bfc00000 4 3c081234 35085678 2409fffd 00085100
M bfc00010 4 01485023 00095f02 014b5026 01486024
M bfc00020 4 394dffff 0120702a 0109782b 2938fffe
M bfc00030 4 313900f0 018d1021 004e1025 004f1021
M bfc00040 4 00581021 00591021 00000008 00000000
V 2121ffeb
E
R alu_ops_stall 50
T load_store 0
M bfc00000 4 24081000 3c09cafe 3529f00d ad090004
M bfc00010 4 8d0a0000 ad0a0008 8d020004 00000008
M bfc00020 1 00000000
M 00001000 1 00000123
V cafef00d
D 00001000 00000123
D 00001004 cafef00d
D 00001008 00000123
E
R load_store_stall 50
T branches 0
M bfc00000 4 24080005 24090005 11090002 34420001
M bfc00010 4 34420100 15090002 34420002 34420004
M bfc00020 4 15000002 34420008 34420200 11000002
M bfc00030 4 34420010 0bf00010 34420020 34420400
M bfc00040 2 00000008 34420040
V 0000007f
E
R branches_stall 50

/* tests/mips_cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module mips_cpu_tb;
  logic                  clk;
  logic                  reset;
  logic                  active;
  logic [`MIPS_XLEN-1:0] register_v0;
  logic [`MIPS_XLEN-1:0] address, writedata;
  logic [`MIPS_XLEN-1:0] readdata = '0;
  logic                  read, write;
  logic                  waitrequest = 1'b0;
  logic [3:0]            byteenable;

  logic [31:0] mem [logic [31:0]];  // sparse word memory, keyed by byte address
  logic [31:0] init_addr[$], init_data[$];
  logic [31:0] check_addr[$], check_data[$];
  logic [31:0] exp_v0;
  string       test_name;
  integer      stall_pct;  // chance of waitrequest per pending cycle
  integer      seed;
  integer      tests_run;

  mips_cpu_bus UUT (
    .clk, .reset, .active, .register_v0,
    .address, .write, .read, .waitrequest, .writedata, .byteenable, .readdata
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // slave side of the avalon port, everything settles on the falling edge
  always @(negedge clk) begin
    waitrequest <= 1'b0;
    if (!reset && (read || write)) begin
      compare_value("byteenable", 32'h0000_000f, {28'h0, byteenable});  // word accesses only
      if (($unsigned($random(seed)) % 100) < stall_pct) begin
        waitrequest <= 1'b1;
      end else if (write) begin
        mem[address] = writedata;  // transfer completes this cycle
      end else begin
        readdata <= mem.exists(address) ? mem[address] : ~address;
      end
    end
  end

  task automatic abort_run(input string reason);
    $display("%0s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected)
      abort_run($sformatf("MISMATCH %0s %0s expected %h actual %h",
                          test_name, what, expected, actual));
  endtask

  task automatic run_test();
    integer k;
    integer cycles;
    mem.delete();
    for (k = 0; k < init_addr.size(); k++) mem[init_addr[k]] = init_data[k];
    @(negedge clk);
    reset = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!active && cycles < 100) begin  // first fetch follows reset
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (!active) abort_run($sformatf("%0s: cpu never became active after reset", test_name));
    cycles = 0;
    while (active && cycles < 5000) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (active) abort_run($sformatf("%0s: cpu did not halt within 5000 cycles", test_name));
    repeat (8) @(negedge clk);  // bus must stay idle after the halt
    compare_value("v0", exp_v0, register_v0);
    for (k = 0; k < check_addr.size(); k++)
      compare_value($sformatf("mem[%h]", check_addr[k]), check_data[k],
                    mem.exists(check_addr[k]) ? mem[check_addr[k]] : ~check_addr[k]);
    $display("%0s: halted after %0d cycles, v0 %h", test_name, cycles, register_v0);
    tests_run = tests_run + 1;
  endtask

  initial begin
    integer      fd, n, c, i, count;
    logic [31:0] a, w;
    string       tag;
    reset     = 1'b1;
    seed      = 32'h1d5d_abe2;
    stall_pct = 0;
    tests_run = 0;
    fd = $fopen("tests/mips_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open tests/mips_vectors.txt");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        case (tag)
          "#": begin  // skip the rest of a comment line
            c = $fgetc(fd);
            while (c != 10 && c != -1) c = $fgetc(fd);
          end
          "T": begin
            n = $fscanf(fd, "%s %d", test_name, stall_pct);
            init_addr.delete();
            init_data.delete();
            check_addr.delete();
            check_data.delete();
          end
          "M": begin
            n = $fscanf(fd, "%h %d", a, count);
            for (i = 0; i < count; i++) begin  // consecutive words from a
              n = $fscanf(fd, "%h", w);
              init_addr.push_back(a + 4 * i);
              init_data.push_back(w);
            end
          end
          "V": n = $fscanf(fd, "%h", exp_v0);
          "D": begin
            n = $fscanf(fd, "%h %h", a, w);
            check_addr.push_back(a);
            check_data.push_back(w);
          end
          "E": run_test();
          "R": begin  // same program and checks, new name and stall rate
            n = $fscanf(fd, "%s %d", test_name, stall_pct);
            run_test();
          end
          default: abort_run({"unknown line tag in vector file: ", tag});
        endcase
      end
      $fclose(fd);
      if (tests_run == 0) begin
        abort_run("vector file holds no tests");
      end else begin
        $display("Regression passed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/mips_cpu_properties.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module mips_cpu_properties (
  input logic                  clk,
  input logic                  reset,
  input logic                  active,
  input logic                  read,
  input logic                  write,
  input logic                  waitrequest,
  input logic [`MIPS_XLEN-1:0] address,
  input logic [`MIPS_XLEN-1:0] writedata
);
  logic was_active;  // active in the previous cycle
  logic halted;      // cpu stopped since the last reset

  always_ff @(posedge clk) begin
    if (reset) begin
      was_active <= 1'b0;
      halted     <= 1'b0;
    end else begin
      was_active <= active;
      if (was_active && !active) halted <= 1'b1;  // falling edge of active
    end
  end

  read_write_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
    else $error("read and write high in the same cycle");

  // a stalled transfer keeps its whole request
  request_stable: assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=> $stable({address, writedata, read, write}))
    else $error("avalon request changed while waitrequest was high");

  quiet_in_reset: assert property (@(posedge clk) reset |=> !read && !write && !active)
    else $error("read, write or active high during reset");

  stays_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !active && !read && !write)
    else $error("cpu became active or used the bus after halting");

endmodule

bind mips_cpu_bus mips_cpu_properties u_props (
  .clk, .reset, .active, .read, .write, .waitrequest, .address, .writedata
);

`default_nettype wire

/* src/mips_cpu_bus.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module mips_cpu_bus import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  active,
  output logic [`MIPS_XLEN-1:0] register_v0,
  // avalon master
  output logic [`MIPS_XLEN-1:0] address,
  output logic                  write,
  output logic                  read,
  input  logic                  waitrequest,
  output logic [`MIPS_XLEN-1:0] writedata,
  output logic [3:0]            byteenable,
  input  logic [`MIPS_XLEN-1:0] readdata
);
  bus_req_t              fetch_req, lsu_req;
  bus_rsp_t              fetch_rsp, lsu_rsp;
  instr_u                instr;           // current instruction register
  ctrl_t                 ctrl;
  logic [`MIPS_XLEN-1:0] imm;
  logic [`MIPS_XLEN-1:0] rs_value, rt_value;
  logic [`MIPS_XLEN-1:0] alu_result, load_data;
  logic                  equal;
  logic                  retire, mem_start, mem_done;

  bus_arbiter u_arbiter (
    .clk, .reset,
    .fetch_req, .fetch_rsp, .lsu_req, .lsu_rsp,
    .address, .writedata, .read, .write, .byteenable,
    .waitrequest, .readdata
  );

  fetch_unit u_fetch (
    .clk, .reset,
    .bus_req(fetch_req), .bus_rsp(fetch_rsp),
    .instr, .ctrl, .imm, .rs_value, .equal,
    .mem_done, .mem_start, .retire, .active
  );

  instr_decoder u_decoder (.instr, .ctrl, .imm);

  register_file u_regs (
    .clk, .reset, .instr, .ctrl, .retire,
    .alu_result, .load_data,
    .rs_value, .rt_value, .register_v0
  );

  alu u_alu (.instr, .ctrl, .imm, .rs_value, .rt_value, .result(alu_result), .equal);

  load_store_unit u_lsu (
    .clk, .reset, .mem_start, .ctrl,
    .addr(alu_result),      // rs + offset
    .store_data(rt_value),
    .bus_req(lsu_req), .bus_rsp(lsu_rsp),
    .load_data, .mem_done
  );

endmodule

`default_nettype wire

/* src/load_store_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module load_store_unit import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  mem_start,
  input  ctrl_t                 ctrl,
  input  logic [`MIPS_XLEN-1:0] addr,
  input  logic [`MIPS_XLEN-1:0] store_data,
  output bus_req_t              bus_req,
  input  bus_rsp_t              bus_rsp,
  output logic [`MIPS_XLEN-1:0] load_data,
  output logic                  mem_done
);
  logic                  pending;  // request on the bus
  logic                  rd_q, wr_q;
  logic [`MIPS_XLEN-1:0] addr_q, data_q;

  assign bus_req.address   = addr_q;
  assign bus_req.read      = pending & rd_q;
  assign bus_req.write     = pending & wr_q;
  assign bus_req.writedata = data_q;

  assign mem_done  = pending & bus_rsp.ready;
  // pass readdata through on completion so write-back lands in the same cycle
  assign load_data = bus_rsp.readdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
    end else if (mem_start) begin
      pending <= 1'b1;
      rd_q    <= ctrl.mem_read;
      wr_q    <= ctrl.mem_write;
    end else if (mem_done) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      addr_q <= {addr[`MIPS_XLEN-1:2], 2'b00};  // word aligned
      data_q <= store_data;
    end
  end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module alu import mips_pkg::*; (
  input  instr_u                instr,
  input  ctrl_t                 ctrl,
  input  logic [`MIPS_XLEN-1:0] imm,
  input  logic [`MIPS_XLEN-1:0] rs_value,
  input  logic [`MIPS_XLEN-1:0] rt_value,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  equal
);
  logic [`MIPS_XLEN-1:0] op_b;
  logic [4:0]            shamt;

  assign op_b  = ctrl.alu_src_imm ? imm : rt_value;
  assign shamt = instr.r.shamt;        // shifts take rt, never rs
  assign equal = (rs_value == rt_value);  // branches always compare rs with rt

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  result = rs_value + op_b;  // addu, addiu and address calc
      ALU_SUB:  result = rs_value - op_b;
      ALU_AND:  result = rs_value & op_b;
      ALU_OR:   result = rs_value | op_b;
      ALU_XOR:  result = rs_value ^ op_b;
      ALU_LUI:  result = {op_b[15:0], 16'h0000};
      ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(rs_value) < $signed(op_b)};
      ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, rs_value < op_b};
      ALU_SLL:  result = op_b << shamt;
      ALU_SRL:  result = op_b >> shamt;   // logical, zero fill
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module register_file import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  instr_u                instr,
  input  ctrl_t                 ctrl,
  input  logic                  retire,
  input  logic [`MIPS_XLEN-1:0] alu_result,
  input  logic [`MIPS_XLEN-1:0] load_data,
  output logic [`MIPS_XLEN-1:0] rs_value,
  output logic [`MIPS_XLEN-1:0] rt_value,
  output logic [`MIPS_XLEN-1:0] register_v0
);
  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
  logic [`MIPS_XLEN-1:0] wb_data;

  assign wb_data = ctrl.mem_read ? load_data : alu_result;  // lw writes memory word

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NREGS; i++) regs[i] <= '0;
    end else if (retire && ctrl.reg_write && ctrl.dest_reg != 5'd0) begin
      regs[ctrl.dest_reg] <= wb_data;
    end
  end

  // $zero always reads back as zero
  assign rs_value    = (instr.r.rs == 5'd0) ? '0 : regs[instr.r.rs];
  assign rt_value    = (instr.r.rt == 5'd0) ? '0 : regs[instr.r.rt];
  assign register_v0 = regs[2];

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module instr_decoder import mips_pkg::*; (
  input  instr_u                instr,
  output ctrl_t                 ctrl,
  output logic [`MIPS_XLEN-1:0] imm
);

  always_comb begin
    ctrl          = '0;
    ctrl.alu_op   = ALU_ADD;
    ctrl.dest_reg = instr.i.rt;  // i-type writes rt
    case (instr.r.opcode)
      OP_SPECIAL: begin
        ctrl.dest_reg  = instr.r.rd;
        ctrl.reg_write = 1'b1;
        case (instr.r.funct)
          F_ADDU: ctrl.alu_op = ALU_ADD;
          F_SUBU: ctrl.alu_op = ALU_SUB;
          F_AND:  ctrl.alu_op = ALU_AND;
          F_OR:   ctrl.alu_op = ALU_OR;
          F_XOR:  ctrl.alu_op = ALU_XOR;
          F_SLT:  ctrl.alu_op = ALU_SLT;
          F_SLTU: ctrl.alu_op = ALU_SLTU;
          F_SLL:  ctrl.alu_op = ALU_SLL;
          F_SRL:  ctrl.alu_op = ALU_SRL;
          F_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump_reg  = 1'b1;
          end
          default: ctrl.reg_write = 1'b0;  // unsupported funct acts as nop
        endcase
      end
      OP_J:   ctrl.jump = 1'b1;
      OP_BEQ: ctrl.branch_eq = 1'b1;  // compare comes from the alu equal flag
      OP_BNE: ctrl.branch_ne = 1'b1;
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        case (instr.i.opcode)
          OP_SLTI: ctrl.alu_op = ALU_SLT;
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          OP_XORI: ctrl.alu_op = ALU_XOR;
          OP_LUI:  ctrl.alu_op = ALU_LUI;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_LW: begin
        ctrl.alu_src_imm = 1'b1;  // address = rs + offset
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ;
    endcase
  end

  // logic immediates are zero extended
  always_comb begin
    case (instr.i.opcode)
      OP_ANDI, OP_ORI, OP_XORI: imm = {{(`MIPS_XLEN-16){1'b0}}, instr.i.imm};
      default:                  imm = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
    endcase
  end

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module fetch_unit import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  output bus_req_t              bus_req,
  input  bus_rsp_t              bus_rsp,
  output instr_u                instr,
  input  ctrl_t                 ctrl,
  input  logic [`MIPS_XLEN-1:0] imm,
  input  logic [`MIPS_XLEN-1:0] rs_value,
  input  logic                  equal,
  input  logic                  mem_done,
  output logic                  mem_start,
  output logic                  retire,
  output logic                  active
);
  // S_START is the idle cycle under reset, first fetch follows it
  typedef enum logic [2:0] {S_START, S_FETCH, S_EXEC, S_MEM, S_HALTED} state_t;

  state_t                state;
  instr_u                ir;
  logic [`MIPS_XLEN-1:0] pc, pc_plus4, next_pc;
  logic [`MIPS_XLEN-1:0] branch_target, jump_target, taken_target;
  logic [`MIPS_XLEN-1:0] target_q;  // where to go after the delay slot
  logic                  delay;     // current instruction sits in a delay slot
  logic                  taken, is_mem;

  assign pc_plus4      = pc + `MIPS_XLEN'd4;
  assign branch_target = pc_plus4 + {imm[`MIPS_XLEN-3:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], ir.j.target, 2'b00};
  assign taken = ctrl.jump | ctrl.jump_reg | (ctrl.branch_eq & equal) | (ctrl.branch_ne & ~equal);
  assign taken_target  = ctrl.jump_reg ? rs_value : (ctrl.jump ? jump_target : branch_target);
  assign next_pc       = delay ? target_q : pc_plus4;
  assign is_mem        = ctrl.mem_read | ctrl.mem_write;

  assign retire    = (state == S_EXEC && !is_mem) || (state == S_MEM && mem_done);
  assign mem_start = (state == S_EXEC) && is_mem;
  assign active    = (state != S_START) && (state != S_HALTED);
  assign instr     = ir;

  // fetch only ever reads
  assign bus_req.address   = pc;
  assign bus_req.read      = (state == S_FETCH);
  assign bus_req.write     = 1'b0;
  assign bus_req.writedata = '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_START;
      pc    <= `MIPS_RESET_VECTOR;
      delay <= 1'b0;
    end else begin
      case (state)
        S_START: state <= S_FETCH;
        S_FETCH: if (bus_rsp.ready) state <= S_EXEC;
        S_EXEC:  if (is_mem) state <= S_MEM;
        default: ;  // S_MEM waits for mem_done, S_HALTED stays
      endcase
      if (retire) begin
        pc    <= next_pc;
        delay <= taken;  // branch or jump opens a delay slot
        state <= (next_pc == `MIPS_HALT_ADDR) ? S_HALTED : S_FETCH;  // halt check before fetch
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH && bus_rsp.ready) ir <= bus_rsp.readdata;
    if (retire && taken) target_q <= taken_target;
  end

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module bus_arbiter import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  bus_req_t              fetch_req,
  output bus_rsp_t              fetch_rsp,
  input  bus_req_t              lsu_req,
  output bus_rsp_t              lsu_rsp,
  output logic [`MIPS_XLEN-1:0] address,
  output logic [`MIPS_XLEN-1:0] writedata,
  output logic                  read,
  output logic                  write,
  output logic [3:0]            byteenable,
  input  logic                  waitrequest,
  input  logic [`MIPS_XLEN-1:0] readdata
);
  logic     hold;          // transfer stalled last cycle, owner is locked
  logic     owner_lsu_q;
  logic     owner_lsu;     // owner in this cycle
  logic     fetch_wants, lsu_wants;
  logic     granted_busy;  // owner has read or write up
  bus_req_t grant_req;

  assign fetch_wants = fetch_req.read | fetch_req.write;
  assign lsu_wants   = lsu_req.read | lsu_req.write;

  // fetch wins when both ask and nobody holds the port
  assign owner_lsu    = hold ? owner_lsu_q : (~fetch_wants & lsu_wants);
  assign grant_req    = owner_lsu ? lsu_req : fetch_req;
  assign granted_busy = grant_req.read | grant_req.write;

  assign address    = grant_req.address;
  assign writedata  = grant_req.writedata;
  assign read       = grant_req.read;
  assign write      = grant_req.write;
  assign byteenable = 4'b1111;  // word accesses only

  always_comb begin
    fetch_rsp = '0;
    lsu_rsp   = '0;
    if (owner_lsu) begin
      lsu_rsp.readdata = readdata;
      lsu_rsp.ready    = granted_busy & ~waitrequest;
    end else begin
      fetch_rsp.readdata = readdata;
      fetch_rsp.ready    = granted_busy & ~waitrequest;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hold        <= 1'b0;
      owner_lsu_q <= 1'b0;
    end else begin
      hold        <= granted_busy & waitrequest;  // keep grant through the stall
      owner_lsu_q <= owner_lsu;
    end
  end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

`include "mips_settings.svh"

package mips_pkg;

  // three views of one instruction word
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_view_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_view_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;   // word index within the 256MB region
  } j_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
    j_view_t j;
  } instr_u;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,  // r-type, decoded by funct
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL  = 6'h00,
    F_SRL  = 6'h02,
    F_JR   = 6'h08,
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_SLT  = 6'h2A,
    F_SLTU = 6'h2B
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_LUI, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL
  } alu_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;  // operand b is the immediate
    logic       reg_write;
    logic [4:0] dest_reg;     // rd or rt, already chosen
    logic       mem_read;
    logic       mem_write;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump;
    logic       jump_reg;
  } ctrl_t;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] address;
    logic                  read;
    logic                  write;
    logic [`MIPS_XLEN-1:0] writedata;
  } bus_req_t;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] readdata;
    logic                  ready;     // transfer completes this cycle
  } bus_rsp_t;

endpackage

`default_nettype wire

/* src/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// first instruction address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// pc value that stops the cpu
`define MIPS_HALT_ADDR 32'h0000_0000

`define MIPS_XLEN 32   // data and address width
`define MIPS_NREGS 32  // general purpose registers

`endif
